//--- Makefile
# Verilator build and run of the SRAM tester testbench

VERILATOR ?= verilator
TOP       ?= sram_tester_tb
FILELIST  ?= sram_tester.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/sram_tester_cfg.svh
// widths and read latency shared by the SRAM tester; data width must be even
`ifndef SRAM_TESTER_CFG_SVH
`define SRAM_TESTER_CFG_SVH

// ########################################
// SRAM geometry
// ########################################

// 8 for simulation, 20 for the hardware part
`define SRAM_ADDR_BITS 8

`define SRAM_DATA_BITS 16  // even widths only, the fill words split in halves

// ########################################
// pipeline
// ########################################

// iterator address to captured read data, fixed by sram_controller
`define SRAM_READ_LAT 2

`endif

//--- common/sram_tester_pkg.sv
// word types and the pattern and phase encodings; widths come from sram_tester_cfg.svh
`include "sram_tester_cfg.svh"

package sram_tester_pkg;

  typedef logic [`SRAM_ADDR_BITS-1:0] addr_t;
  typedef logic [`SRAM_DATA_BITS-1:0] data_t;

  // fill patterns in test order
  typedef enum logic [2:0] {
    pat_zeros,
    pat_ones,
    pat_check_a,    // 0101...
    pat_check_b,    // 1010...
    pat_low_half,
    pat_high_half,
    pat_address     // data is the low address bits
  } pattern_e;

  // test controller phases
  typedef enum logic [2:0] {
    ph_idle,
    ph_write,
    ph_read,
    ph_drain,       // wait for the read pipeline to empty
    ph_next,
    ph_done
  } phase_e;

endpackage

//--- hdl/addr_iter.sv
// address counter, wraps to zero past the maximum; restart has priority over step
`timescale 1ns/10ps

module addr_iter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   restart,
  input  logic                   step,
  output sram_tester_pkg::addr_t addr,
  output logic                   last
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr <= '0;
    end else if (restart) begin
      addr <= '0;
    end else if (step) begin
      addr <= addr + 1'b1;  // natural wrap
    end
  end

  assign last = (addr == '1);

endmodule

//--- hdl/pattern_generator.sv
// pat_address yields zero here, the top level substitutes the address; data width must be even
`timescale 1ns/10ps
`include "sram_tester_cfg.svh"

module pattern_generator (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      restart,
  input  logic                      step,
  output sram_tester_pkg::data_t    pattern,
  output sram_tester_pkg::pattern_e pattern_idx,
  output logic                      last
);

  import sram_tester_pkg::*;

  localparam int HALF = `SRAM_DATA_BITS / 2;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pattern_idx <= pat_zeros;
    end else if (restart) begin
      pattern_idx <= pat_zeros;
    end else if (step) begin
      pattern_idx <= pattern_e'(pattern_idx + 3'd1);
    end
  end

  assign last = (pattern_idx == pat_address);

  // fill word decode
  always_comb begin
    case (pattern_idx)
      pat_zeros:     pattern = '0;
      pat_ones:      pattern = '1;
      pat_check_a:   pattern = {HALF{2'b01}};
      pat_check_b:   pattern = {HALF{2'b10}};
      pat_low_half:  pattern = {{HALF{1'b0}}, {HALF{1'b1}}};
      pat_high_half: pattern = {{HALF{1'b1}}, {HALF{1'b0}}};
      default:       pattern = '0;  // pat_address
    endcase
  end

endmodule

//--- hdl/result_checker.sv
// pass flag is sticky until reset; only the first mismatching pair is kept
`timescale 1ns/10ps

module result_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   check_en,
  input  sram_tester_pkg::data_t read_data,
  input  sram_tester_pkg::data_t expected,
  output logic                   test_pass,
  output sram_tester_pkg::data_t fail_read,
  output sram_tester_pkg::data_t fail_expected
);

  logic mismatch;

  assign mismatch = check_en && (read_data != expected);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_pass     <= 1'b1;
      fail_read     <= '0;
      fail_expected <= '0;
    end else if (mismatch && test_pass) begin
      test_pass     <= 1'b0;
      fail_read     <= read_data;  // first failure only
      fail_expected <= expected;
    end
  end

endmodule

//--- hdl/sram_tester.sv
// SRAM self-test top; starts on reset release, no host interface, asynchronous SRAM with no wait states
`timescale 1ns/10ps

module sram_tester (
  input  logic                      clk,
  input  logic                      reset,
  output sram_tester_pkg::addr_t    addr_bus,
  inout  wire sram_tester_pkg::data_t data_bus,
  output logic                      we_n,
  output logic                      oe_n,
  output logic                      ce_n,
  output logic                      test_done,
  output logic                      test_pass,
  output sram_tester_pkg::pattern_e pattern_state,
  output sram_tester_pkg::phase_e   test_state,
  output sram_tester_pkg::data_t    prev_read_data,
  output sram_tester_pkg::data_t    prev_expected_data
);

  import sram_tester_pkg::*;

  addr_t addr;
  addr_t read_addr;
  data_t pattern;
  data_t wdata;
  data_t read_data;
  data_t expected;
  logic  addr_last, addr_restart, addr_step;
  logic  pattern_last, pattern_restart, pattern_step;
  logic  read_only, access_active, check_en;

  // ########################################
  // address pattern substitution
  // ########################################

  assign wdata    = (pattern_state == pat_address) ? data_t'(addr) : pattern;
  assign expected = (pattern_state == pat_address) ? data_t'(read_addr) : pattern;

  sram_controller sram_ctrl (
    .clk(clk), .reset(reset),
    .addr(addr), .wdata(wdata),
    .read_only(read_only), .access_active(access_active),
    .addr_bus(addr_bus), .data_bus(data_bus),
    .we_n(we_n), .oe_n(oe_n), .ce_n(ce_n),
    .read_data(read_data), .read_addr(read_addr)
  );

  pattern_generator pattern_gen (
    .clk(clk), .reset(reset),
    .restart(pattern_restart), .step(pattern_step),
    .pattern(pattern), .pattern_idx(pattern_state), .last(pattern_last)
  );

  addr_iter addr_gen (
    .clk(clk), .reset(reset),
    .restart(addr_restart), .step(addr_step),
    .addr(addr), .last(addr_last)
  );

  test_controller test_ctrl (
    .clk(clk), .reset(reset),
    .addr_last(addr_last), .pattern_last(pattern_last), .fail(~test_pass),
    .read_only(read_only), .access_active(access_active),
    .addr_restart(addr_restart), .addr_step(addr_step),
    .pattern_restart(pattern_restart), .pattern_step(pattern_step),
    .check_en(check_en), .test_done(test_done), .test_state(test_state)
  );

  result_checker result_check (
    .clk(clk), .reset(reset),
    .check_en(check_en), .read_data(read_data), .expected(expected),
    .test_pass(test_pass),
    .fail_read(prev_read_data), .fail_expected(prev_expected_data)
  );

endmodule

//--- hdl/test_controller.sv
// one pattern is write pass, read pass, drain of SRAM_READ_LAT+1 cycles and one advance cycle
`timescale 1ns/10ps
`include "sram_tester_cfg.svh"

module test_controller (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    addr_last,
  input  logic                    pattern_last,
  input  logic                    fail,
  output logic                    read_only,
  output logic                    access_active,
  output logic                    addr_restart,
  output logic                    addr_step,
  output logic                    pattern_restart,
  output logic                    pattern_step,
  output logic                    check_en,
  output logic                    test_done,
  output sram_tester_pkg::phase_e test_state
);

  import sram_tester_pkg::*;

  localparam int LAT     = `SRAM_READ_LAT;
  localparam int DRAIN_W = $clog2(LAT + 1);

  phase_e             next_state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic [LAT-1:0]     rd_pipe;

  // ########################################
  // phase machine
  // ########################################

  always_comb begin
    next_state = test_state;
    case (test_state)
      ph_idle:  next_state = ph_write;
      ph_write: if (addr_last) next_state = ph_read;
      ph_read:  if (addr_last) next_state = ph_drain;
      // one cycle past the latency so the last compare is seen as fail
      ph_drain: if (drain_cnt == DRAIN_W'(LAT)) next_state = ph_next;
      ph_next:  next_state = pattern_last ? ph_done : ph_write;
      default:  next_state = ph_done;
    endcase
    if (fail) begin
      next_state = ph_done;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_state <= ph_idle;
      test_done  <= 1'b0;
      drain_cnt  <= '0;
      rd_pipe    <= '0;
    end else begin
      test_state <= next_state;
      if (next_state == ph_done) begin
        test_done <= 1'b1;  // held until reset
      end
      drain_cnt <= (test_state == ph_drain) ? drain_cnt + 1'b1 : '0;
      rd_pipe   <= (rd_pipe << 1) | LAT'(test_state == ph_read);
    end
  end

  assign check_en = rd_pipe[LAT-1];  // lines up with read_data

  // ########################################
  // strobes
  // ########################################

  assign read_only       = (test_state != ph_write);
  assign access_active   = (test_state == ph_write) || (test_state == ph_read);
  assign addr_step       = access_active;  // wrap to 0 starts the next pass
  assign addr_restart    = (test_state == ph_idle) || (test_state == ph_next);
  assign pattern_restart = (test_state == ph_idle);
  assign pattern_step    = (test_state == ph_next) && !pattern_last;

endmodule

//--- sram_ctrl/sram_controller.sv
// one access per cycle, no wait states; read data and its address appear two edges after the request
`timescale 1ns/10ps

module sram_controller (
  input  logic                   clk,
  input  logic                   reset,
  input  sram_tester_pkg::addr_t addr,
  input  sram_tester_pkg::data_t wdata,
  input  logic                   read_only,
  input  logic                   access_active,
  output sram_tester_pkg::addr_t addr_bus,
  inout  wire sram_tester_pkg::data_t data_bus,
  output logic                   we_n,
  output logic                   oe_n,
  output logic                   ce_n,
  output sram_tester_pkg::data_t read_data,
  output sram_tester_pkg::addr_t read_addr
);

  import sram_tester_pkg::*;

  data_t wdata_q;

  // ########################################
  // request stage, onto the pins
  // ########################################

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr_bus <= '0;
      we_n     <= 1'b1;
      oe_n     <= 1'b1;
      ce_n     <= 1'b1;
    end else begin
      addr_bus <= addr;
      we_n     <= ~(access_active & ~read_only);
      oe_n     <= ~(access_active & read_only);
      ce_n     <= ~access_active;  // no strobes in idle cycles
    end
  end

  always_ff @(posedge clk) begin
    wdata_q <= wdata;
  end

  assign data_bus = we_n ? 'z : wdata_q;  // drive only during a write strobe

  // ########################################
  // return stage
  // ########################################

  always_ff @(posedge clk) begin
    if (!oe_n) begin
      read_data <= data_bus;
      read_addr <= addr_bus;  // keeps the address with its data
    end
  end

endmodule

//--- sram_tester.f
+incdir+common
common/sram_tester_pkg.sv
sram_ctrl/sram_controller.sv
hdl/pattern_generator.sv
hdl/addr_iter.sv
hdl/test_controller.sv
hdl/result_checker.sv
hdl/sram_tester.sv
testbench/sram_model.sv
testbench/sram_tester_assert.sv
testbench/sram_tester_tb.sv

//--- testbench/sram_model.sv
// async SRAM model; writes commit at the clock edge that ends a bus cycle, one fault kind at a time
`timescale 1ns/10ps

module sram_model (
  input  logic                   clk,
  input  sram_tester_pkg::addr_t addr_bus,
  inout  wire sram_tester_pkg::data_t data_bus,
  input  logic                   we_n,
  input  logic                   oe_n,
  input  logic                   ce_n,
  input  logic [1:0]             fault_kind,
  input  sram_tester_pkg::addr_t fault_addr,
  input  logic [$clog2($bits(sram_tester_pkg::data_t))-1:0] fault_bit,
  input  logic [$clog2($bits(sram_tester_pkg::addr_t))-1:0] alias_bit
);

  import sram_tester_pkg::*;

  localparam logic [1:0] STUCK_1 = 2'd1;
  localparam logic [1:0] STUCK_0 = 2'd2;
  localparam logic [1:0] ALIAS   = 2'd3;

  data_t mem [2 ** $bits(addr_t)];
  addr_t eff_addr;
  data_t rd_word;

  always_comb begin
    eff_addr = addr_bus;
    if (fault_kind == ALIAS) begin
      eff_addr[alias_bit] = 1'b0;  // address line shorted low
    end
  end

  always_comb begin
    rd_word = mem[eff_addr];
    if (addr_bus == fault_addr && fault_kind == STUCK_1) begin
      rd_word[fault_bit] = 1'b1;
    end
    if (addr_bus == fault_addr && fault_kind == STUCK_0) begin
      rd_word[fault_bit] = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!ce_n && !we_n) begin
      mem[eff_addr] <= data_bus;
    end
  end

  assign data_bus = (!ce_n && !oe_n && we_n) ? rd_word : 'z;

endmodule

//--- testbench/sram_tester_assert.sv
// pin strobe and status flag checks, bound into every sram_tester instance
`timescale 1ns/10ps

module sram_tester_assert (
  input logic clk,
  input logic reset,
  input logic we_n,
  input logic oe_n,
  input logic ce_n,
  input logic test_pass,
  input logic test_done
);

  // ########################################
  // pin protocol
  // ########################################

  strobe_exclusive: assert property (@(posedge clk) !(!we_n && !oe_n))
    else $error("we_n and oe_n low in the same cycle");

  chip_enable: assert property (@(posedge clk) (!we_n || !oe_n) |-> !ce_n)
    else $error("strobe low while ce_n is high");

  // status flags, only reset may move them back
  pass_rise: assert property (@(posedge clk) $rose(test_pass) |-> reset)
    else $error("test_pass rose outside reset");

  done_hold: assert property (@(posedge clk) $fell(test_done) |-> reset)
    else $error("test_done fell outside reset");

endmodule

bind sram_tester sram_tester_assert u_assert (
  .clk(clk), .reset(reset),
  .we_n(we_n), .oe_n(oe_n), .ce_n(ce_n),
  .test_pass(test_pass), .test_done(test_done)
);

//--- testbench/sram_tester_tb.sv
// one fault entry per run from reset to test_done; cycle count check assumes the fixed read latency
`timescale 1ns/10ps
`include "sram_tester_cfg.svh"

module sram_tester_tb;

  import sram_tester_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int PAT_CYCLES = 2 * (2 ** `SRAM_ADDR_BITS) + `SRAM_READ_LAT + 2;
  localparam int RUN_CYCLES = 7 * PAT_CYCLES + 1;
  localparam int N_ENTRIES  = 6;
  localparam int BIT_W      = $clog2(`SRAM_DATA_BITS);
  localparam int ABIT_W     = $clog2(`SRAM_ADDR_BITS);
  localparam longint WATCHDOG_NS = longint'(N_ENTRIES) * 7
                                   * (2 * (longint'(1) << `SRAM_ADDR_BITS) + 8) * 2 * CLK_PERIOD;

  localparam logic [1:0] NO_FAULT = 2'd0;
  localparam logic [1:0] STUCK_1  = 2'd1;
  localparam logic [1:0] STUCK_0  = 2'd2;
  localparam logic [1:0] ALIAS    = 2'd3;

  typedef struct packed {
    logic [1:0] kind;
    addr_t      f_addr;
    int         f_bit;
    int         a_bit;
    int         abort_at;  // nonzero: reset again after this many cycles
    logic       exp_pass;
    data_t      exp_read;
    data_t      exp_expected;
    pattern_e   exp_pattern;
    phase_e     exp_phase;
  } entry_t;

  logic              clk;
  logic              reset;
  addr_t             addr_bus;
  wire data_t        data_bus;
  logic              we_n;
  logic              oe_n;
  logic              ce_n;
  logic              test_done;
  logic              test_pass;
  pattern_e          pattern_state;
  phase_e            test_state;
  data_t             prev_read_data;
  data_t             prev_expected_data;
  logic [1:0]        fault_kind;
  addr_t             fault_addr;
  logic [BIT_W-1:0]  fault_bit;
  logic [ABIT_W-1:0] alias_bit;

  entry_t table_q [N_ENTRIES];
  int     n_pass;
  int     n_fail;
  logic   entry_fail;

  sram_tester dut (
    .clk(clk), .reset(reset),
    .addr_bus(addr_bus), .data_bus(data_bus),
    .we_n(we_n), .oe_n(oe_n), .ce_n(ce_n),
    .test_done(test_done), .test_pass(test_pass),
    .pattern_state(pattern_state), .test_state(test_state),
    .prev_read_data(prev_read_data), .prev_expected_data(prev_expected_data)
  );

  sram_model sram (
    .clk(clk), .addr_bus(addr_bus), .data_bus(data_bus),
    .we_n(we_n), .oe_n(oe_n), .ce_n(ce_n),
    .fault_kind(fault_kind), .fault_addr(fault_addr),
    .fault_bit(fault_bit), .alias_bit(alias_bit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: test_done never rose within the expected run time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic string kind_name(input logic [1:0] kind);
    case (kind)
      STUCK_1: return "stuck-1";
      STUCK_0: return "stuck-0";
      ALIAS:   return "alias";
      default: return "none";
    endcase
  endfunction

  task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", sig, got, exp);
      entry_fail = 1'b1;
    end
  endtask

  // ########################################
  // per-entry sequencing
  // ########################################

  task automatic apply_reset(input entry_t e);
    @(posedge clk);
    reset      <= 1'b1;
    fault_kind <= e.kind;
    fault_addr <= e.f_addr;
    fault_bit  <= BIT_W'(e.f_bit);
    alias_bit  <= ABIT_W'(e.a_bit);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_word("test_done", test_done, 0);  // idle values in reset
    check_word("test_pass", test_pass, 1);
    check_word("test_state", test_state, ph_idle);
    check_word("we_n", we_n, 1);
    check_word("oe_n", oe_n, 1);
    check_word("ce_n", ce_n, 1);
    check_word("prev_read_data", prev_read_data, 0);
    check_word("prev_expected_data", prev_expected_data, 0);
    @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    int cycles;
    cycles = 0;
    if (e.abort_at != 0) begin
      repeat (e.abort_at) @(posedge clk);
      @(negedge clk);
      check_word("test_done", test_done, 0);  // still mid-run
    end else begin
      do begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
      end while (!test_done);
      if (e.kind == NO_FAULT) begin
        check_word("test_done cycle", cycles, RUN_CYCLES);
      end
    end
    check_word("test_pass", test_pass, e.exp_pass);
    check_word("prev_read_data", prev_read_data, e.exp_read);
    check_word("prev_expected_data", prev_expected_data, e.exp_expected);
    check_word("pattern_state", pattern_state, e.exp_pattern);
    check_word("test_state", test_state, e.exp_phase);
  endtask

  initial begin : main
    reset      = 1'b1;
    fault_kind = NO_FAULT;
    fault_addr = '0;
    fault_bit  = '0;
    alias_bit  = '0;
    n_pass     = 0;
    n_fail     = 0;
    entry_fail = 1'b0;

    // kind, addr, bit, alias bit, abort, pass, read word, expected word, pattern, phase
    table_q[0] = '{NO_FAULT, '0, 0, 0, 0, 1'b1, '0, '0, pat_address, ph_done};
    table_q[1] = '{STUCK_1, addr_t'(8'h3c), 5, 0, 0, 1'b0, data_t'(1) << 5, '0,
                   pat_zeros, ph_done};
    table_q[2] = '{STUCK_0, addr_t'(8'ha7), 11, 0, 0, 1'b0,
                   ~(data_t'(1) << 11), ~data_t'(0), pat_ones, ph_done};
    table_q[3] = '{ALIAS, '0, 0, 6, 0, 1'b0, data_t'(1) << 6, '0, pat_address, ph_done};
    table_q[4] = '{NO_FAULT, '0, 0, 0, PAT_CYCLES + PAT_CYCLES / 2, 1'b1, '0, '0,
                   pat_ones, ph_read};
    table_q[5] = '{NO_FAULT, '0, 0, 0, 0, 1'b1, '0, '0,
                   pat_address, ph_done};  // after the abort

    for (int i = 0; i < N_ENTRIES; i++) begin
      entry_fail = 1'b0;
      apply_reset(table_q[i]);
      run_entry(table_q[i]);
      if (entry_fail) begin
        n_fail++;
      end else begin
        n_pass++;
      end
      $display("entry %0d fault %s: %s", i, kind_name(table_q[i].kind),
               entry_fail ? "mismatch" : "ok");
    end

    $display("entries %0d, passed %0d, failed %0d", N_ENTRIES, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
